// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_vdp
FILELIST  := tb.f
OBJ_DIR   := obj_dir

SOURCES   := $(shell cat $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a nonzero exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb.f ====
vdp_pkg.sv
vdp_csr.sv
vdp_ctrl.sv
vdp_vector_buf.sv
vdp_dot_unit.sv
vdp_top.sv
tb_vdp_mem.sv
tb_vdp.sv

// ==== tb_vdp.sv ====
module tb_vdp;
  import vdp_pkg::*;

  localparam int mem_words_lp = 128;
  localparam int mem_idx_width_lp = $clog2(mem_words_lp);
  localparam int watchdog_margin_lp = 2000;

  logic clk = 1'b0;
  logic reset;
  logic csr_w_v;
  logic csr_r_v;
  logic [csr_addr_width_gp-1:0] csr_addr;
  logic [word_width_gp-1:0] csr_wdata;
  logic [word_width_gp-1:0] csr_rdata;
  logic csr_rdata_v;
  logic mem_req_v;
  logic mem_we;
  logic [word_width_gp-1:0] mem_addr;
  logic [word_width_gp-1:0] mem_wdata;
  logic mem_resp_v;
  logic [word_width_gp-1:0] mem_rdata;
  logic poke_v;
  logic [mem_idx_width_lp-1:0] poke_idx;
  logic [word_width_gp-1:0] poke_data;
  logic [mem_idx_width_lp-1:0] peek_idx;
  logic [word_width_gp-1:0] peek_data;
  logic [31:0] lcg_state = 32'd61715;
  logic [2:0] mem_lat;

  logic [word_width_gp-1:0] testdata [0:63];
  logic [word_width_gp-1:0] shadow [mem_words_lp];
  int n_cases;
  int watchdog_cycles = 0;

  always #4 clk = ~clk;

  vdp_top #(.vec_els_p(vec_els_gp)) i_dut (
    .clk_i(clk),
    .reset_i(reset),
    .csr_w_v_i(csr_w_v),
    .csr_r_v_i(csr_r_v),
    .csr_addr_i(csr_addr),
    .csr_wdata_i(csr_wdata),
    .csr_rdata_o(csr_rdata),
    .csr_rdata_v_o(csr_rdata_v),
    .mem_req_v_o(mem_req_v),
    .mem_we_o(mem_we),
    .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata),
    .mem_resp_v_i(mem_resp_v),
    .mem_rdata_i(mem_rdata)
  );

  tb_vdp_mem #(.words_p(mem_words_lp)) i_mem (
    .clk_i(clk),
    .reset_i(reset),
    .req_v_i(mem_req_v),
    .we_i(mem_we),
    .addr_i(mem_addr),
    .wdata_i(mem_wdata),
    .lat_i(mem_lat),
    .resp_v_o(mem_resp_v),
    .rdata_o(mem_rdata),
    .poke_v_i(poke_v),
    .poke_idx_i(poke_idx),
    .poke_data_i(poke_data),
    .peek_idx_i(peek_idx),
    .peek_data_o(peek_data)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // an odd multiplier lets every bit of the index change the pattern
  function automatic logic [word_width_gp-1:0] fill_word(input int idx);
    return 64'hA5A5_0000_0000_0000 ^ (64'(idx) * 64'h9E37_79B9_7F4A_7C15);
  endfunction

  function automatic logic addr_ok(input logic [word_width_gp-1:0] addr);
    return (addr[2:0] == 3'd0) && (addr < 64'(mem_words_lp * word_bytes_gp));
  endfunction

  // new memory latency of 1 to 4 cycles for every request
  always @(posedge clk) begin
    if (mem_req_v) begin
      lcg_state <= lcg_next(lcg_state);
    end
  end
  assign mem_lat = 3'd1 + {1'b0, lcg_state[17:16]};

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [word_width_gp-1:0] got,
                             input logic [word_width_gp-1:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%016h expected 0x%016h", name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  // all driving tasks start and end one time unit after a rising edge
  task automatic poke_word(input logic [mem_idx_width_lp-1:0] idx,
                           input logic [word_width_gp-1:0] data);
    poke_v = 1'b1;
    poke_idx = idx;
    poke_data = data;
    @(posedge clk);
    #1;
    poke_v = 1'b0;
  endtask

  task automatic place_word(input logic [word_width_gp-1:0] addr,
                            input logic [word_width_gp-1:0] data);
    if (!addr_ok(addr)) begin
      fail_run("test data points outside the memory model");
    end
    shadow[addr[mem_idx_width_lp+2:3]] = data;
    poke_word(addr[mem_idx_width_lp+2:3], data);
  endtask

  task automatic write_reg(input logic [csr_addr_width_gp-1:0] addr,
                           input logic [word_width_gp-1:0] data);
    csr_w_v = 1'b1;
    csr_addr = addr;
    csr_wdata = data;
    @(posedge clk);
    #1;
    csr_w_v = 1'b0;
    // no read strobe in the previous cycle
    check_value("csr_rdata_v_o", 64'(csr_rdata_v), 64'd0);
  endtask

  task automatic read_reg(input logic [csr_addr_width_gp-1:0] addr,
                          output logic [word_width_gp-1:0] data);
    csr_r_v = 1'b1;
    csr_addr = addr;
    @(posedge clk);
    #1;
    csr_r_v = 1'b0;
    // read data is valid in the cycle after the strobe
    check_value("csr_rdata_v_o", 64'(csr_rdata_v), 64'd1);
    data = csr_rdata;
  endtask

  task automatic compare_memory();
    for (int i = 0; i < mem_words_lp; i++) begin
      peek_idx = mem_idx_width_lp'(i);
      #1;
      check_value($sformatf("mem[0x%0h]", i * word_bytes_gp), peek_data, shadow[i]);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_reset_values();
    logic [word_width_gp-1:0] rd;
    check_value("mem_req_v_o", 64'(mem_req_v), 64'd0);
    check_value("csr_rdata_v_o", 64'(csr_rdata_v), 64'd0);
    read_reg(e_csr_status, rd);
    check_value("csr_status", rd, 64'd1);
    read_reg(e_csr_start, rd);
    check_value("csr_start", rd, 64'd0);
    read_reg(e_csr_a_ptr, rd);
    check_value("csr_a_ptr", rd, 64'd0);
    read_reg(e_csr_b_ptr, rd);
    check_value("csr_b_ptr", rd, 64'd0);
    read_reg(e_csr_len, rd);
    check_value("csr_len", rd, 64'd0);
    read_reg(e_csr_res_ptr, rd);
    check_value("csr_res_ptr", rd, 64'd0);
  endtask

  task automatic check_reg_access();
    logic [word_width_gp-1:0] rd;
    write_reg(e_csr_a_ptr, 64'h0123_4567_89ab_cdef);
    write_reg(e_csr_b_ptr, 64'hfedc_ba98_7654_3210);
    write_reg(e_csr_len, 64'h0000_0000_0000_0005);
    write_reg(e_csr_res_ptr, 64'h5555_aaaa_5555_aaaa);
    write_reg(4'd6, 64'hffff_ffff_ffff_ffff);
    read_reg(e_csr_a_ptr, rd);
    check_value("csr_a_ptr", rd, 64'h0123_4567_89ab_cdef);
    read_reg(e_csr_b_ptr, rd);
    check_value("csr_b_ptr", rd, 64'hfedc_ba98_7654_3210);
    read_reg(e_csr_len, rd);
    check_value("csr_len", rd, 64'h0000_0000_0000_0005);
    read_reg(e_csr_res_ptr, rd);
    check_value("csr_res_ptr", rd, 64'h5555_aaaa_5555_aaaa);
    read_reg(4'd6, rd);
    check_value("csr addr 0x6", rd, 64'd0);
    read_reg(4'hf, rd);
    check_value("csr addr 0xf", rd, 64'd0);
  endtask

  task automatic run_case(inout int pos);
    logic [word_width_gp-1:0] len;
    logic [word_width_gp-1:0] a_ptr;
    logic [word_width_gp-1:0] b_ptr;
    logic [word_width_gp-1:0] res_ptr;
    logic [word_width_gp-1:0] a_el;
    logic [word_width_gp-1:0] b_el;
    logic [word_width_gp-1:0] expected;
    logic [word_width_gp-1:0] rd;
    int n;
    len = testdata[pos];
    a_ptr = testdata[pos + 1];
    b_ptr = testdata[pos + 2];
    res_ptr = testdata[pos + 3];
    if (len < 64'd1 || len > 64'(vec_els_gp) || !addr_ok(res_ptr)) begin
      fail_run("test data holds a bad length or result pointer");
    end
    n = int'(len);
    expected = '0;
    for (int i = 0; i < n; i++) begin
      a_el = testdata[pos + 4 + i];
      b_el = testdata[pos + 4 + n + i];
      // products and sum wrap at 64 bits
      expected = expected + a_el * b_el;
      place_word(a_ptr + 64'(i) * 64'(word_bytes_gp), a_el);
      place_word(b_ptr + 64'(i) * 64'(word_bytes_gp), b_el);
    end
    pos = pos + 4 + 2 * n;
    $display("case: len %0d a 0x%0h b 0x%0h res 0x%0h", n, a_ptr, b_ptr, res_ptr);
    write_reg(e_csr_a_ptr, a_ptr);
    write_reg(e_csr_b_ptr, b_ptr);
    write_reg(e_csr_len, len);
    write_reg(e_csr_res_ptr, res_ptr);
    write_reg(e_csr_start, 64'd1);
    // status has dropped by the time the start readback is done
    read_reg(e_csr_start, rd);
    check_value("csr_start", rd, 64'd1);
    read_reg(e_csr_status, rd);
    check_value("csr_status", rd, 64'd0);
    rd = '0;
    while (rd !== 64'd1) begin
      read_reg(e_csr_status, rd);
    end
    read_reg(e_csr_start, rd);
    check_value("csr_start", rd, 64'd0);
    shadow[res_ptr[mem_idx_width_lp+2:3]] = expected;
    compare_memory();
  endtask

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    fail_run("timeout: the test sequence did not complete in time");
  end

  initial begin
    int pos;
    reset = 1'b1;
    csr_w_v = 1'b0;
    csr_r_v = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    poke_v = 1'b0;
    poke_idx = '0;
    poke_data = '0;
    peek_idx = '0;
    $readmemh("vdp_testdata.txt", testdata);
    n_cases = int'(testdata[0]);
    if (n_cases < 1 || n_cases > 8) begin
      fail_run("test data file is missing or its case count is out of range");
    end
    // every case issues up to 2 * 8 reads and one write with up to 4 cycles of latency each
    watchdog_cycles = n_cases * (2 * vec_els_gp + 1) * 4 + watchdog_margin_lp;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < mem_words_lp; i++) begin
      shadow[i] = fill_word(i);
      poke_word(mem_idx_width_lp'(i), shadow[i]);
    end
    check_reset_values();
    check_reg_access();
    pos = 1;
    for (int c = 0; c < n_cases; c++) begin
      run_case(pos);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== tb_vdp_mem.sv ====
module tb_vdp_mem #(
  parameter  int words_p      = 128,
  localparam int idx_width_lp = $clog2(words_p)
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              req_v_i,
  input  logic                              we_i,
  input  logic [vdp_pkg::word_width_gp-1:0] addr_i,
  input  logic [vdp_pkg::word_width_gp-1:0] wdata_i,
  input  logic [2:0]                        lat_i,
  output logic                              resp_v_o,
  output logic [vdp_pkg::word_width_gp-1:0] rdata_o,
  input  logic                              poke_v_i,
  input  logic [idx_width_lp-1:0]           poke_idx_i,
  input  logic [vdp_pkg::word_width_gp-1:0] poke_data_i,
  input  logic [idx_width_lp-1:0]           peek_idx_i,
  output logic [vdp_pkg::word_width_gp-1:0] peek_data_o
);
  import vdp_pkg::*;

  logic [word_width_gp-1:0] mem [words_p];
  logic pend = 1'b0;
  logic we_q = 1'b0;
  logic [idx_width_lp-1:0] idx_q = '0;
  logic [word_width_gp-1:0] wdata_q = '0;
  logic resp_n = 1'b0;
  logic [word_width_gp-1:0] rdata_n = '0;
  logic resp_q = 1'b0;
  logic [word_width_gp-1:0] rdata_q = '0;
  int left = 0;

  // one request at a time is answered after lat_i cycles
  always @(posedge clk_i) begin
    resp_n = 1'b0;
    if (reset_i) begin
      pend = 1'b0;
    end else begin
      if (poke_v_i) begin
        mem[poke_idx_i] = poke_data_i;
      end
      if (pend) begin
        left = left - 1;
        if (left == 0) begin
          pend = 1'b0;
          resp_n = 1'b1;
          if (we_q) begin
            mem[idx_q] = wdata_q;
          end else begin
            rdata_n = mem[idx_q];
          end
        end
      end else if (req_v_i) begin
        pend = 1'b1;
        left = int'(lat_i);
        we_q = we_i;
        idx_q = addr_i[idx_width_lp+2:3];
        wdata_q = wdata_i;
      end
    end
    #1;
    resp_q = resp_n;
    rdata_q = rdata_n;
  end

  assign resp_v_o = resp_q;
  assign rdata_o = rdata_q;
  assign peek_data_o = mem[peek_idx_i];

endmodule

// ==== vdp_csr.sv ====
module vdp_csr (
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  input  logic                                  csr_w_v_i,
  input  logic                                  csr_r_v_i,
  input  logic [vdp_pkg::csr_addr_width_gp-1:0] csr_addr_i,
  input  logic [vdp_pkg::word_width_gp-1:0]     csr_wdata_i,
  output logic [vdp_pkg::word_width_gp-1:0]     csr_rdata_o,
  output logic                                  csr_rdata_v_o,

  input  logic                                  done_i,
  input  logic                                  idle_i,
  output logic [vdp_pkg::word_width_gp-1:0]     a_ptr_o,
  output logic [vdp_pkg::word_width_gp-1:0]     b_ptr_o,
  output logic [vdp_pkg::word_width_gp-1:0]     len_o,
  output logic [vdp_pkg::word_width_gp-1:0]     res_ptr_o,
  output logic                                  start_o
);
  import vdp_pkg::*;

  logic [word_width_gp-1:0] a_ptr_r, b_ptr_r, len_r, start_r, res_ptr_r;
  logic [word_width_gp-1:0] rdata_n;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_r   <= '0;
      b_ptr_r   <= '0;
      len_r     <= '0;
      start_r   <= '0;
      res_ptr_r <= '0;
    end else begin
      if (csr_w_v_i) begin
        case (csr_idx_e'(csr_addr_i))
          e_csr_a_ptr:   a_ptr_r   <= csr_wdata_i;
          e_csr_b_ptr:   b_ptr_r   <= csr_wdata_i;
          e_csr_len:     len_r     <= csr_wdata_i;
          e_csr_start:   start_r   <= csr_wdata_i;
          e_csr_res_ptr: res_ptr_r <= csr_wdata_i;
          default: begin
          end
        endcase
      end
      // completion wins over a start write in the same cycle
      if (done_i) begin
        start_r <= '0;
      end
    end
  end

  always_comb begin
    case (csr_idx_e'(csr_addr_i))
      e_csr_a_ptr:   rdata_n = a_ptr_r;
      e_csr_b_ptr:   rdata_n = b_ptr_r;
      e_csr_len:     rdata_n = len_r;
      e_csr_start:   rdata_n = start_r;
      e_csr_status:  rdata_n = word_width_gp'(idle_i);
      e_csr_res_ptr: rdata_n = res_ptr_r;
      default:       rdata_n = '0;
    endcase
  end

  // read data follows the strobe by one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      csr_rdata_v_o <= 1'b0;
    end else begin
      csr_rdata_v_o <= csr_r_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (csr_r_v_i) begin
      csr_rdata_o <= rdata_n;
    end
  end

  assign a_ptr_o   = a_ptr_r;
  assign b_ptr_o   = b_ptr_r;
  assign len_o     = len_r;
  assign res_ptr_o = res_ptr_r;
  assign start_o   = |start_r;

endmodule

// ==== vdp_ctrl.sv ====
module vdp_ctrl #(
  parameter  int vec_els_p    = vdp_pkg::vec_els_gp,
  localparam int cnt_width_lp = $clog2(vec_els_p + 1)
) (
  input  logic                              clk_i,
  input  logic                              reset_i,

  input  logic                              start_i,
  input  logic [vdp_pkg::word_width_gp-1:0] a_ptr_i,
  input  logic [vdp_pkg::word_width_gp-1:0] b_ptr_i,
  input  logic [vdp_pkg::word_width_gp-1:0] len_i,
  input  logic [vdp_pkg::word_width_gp-1:0] res_ptr_i,
  input  logic [cnt_width_lp-1:0]           cnt_a_i,
  input  logic [cnt_width_lp-1:0]           cnt_b_i,
  input  logic [vdp_pkg::word_width_gp-1:0] dot_i,

  output logic                              mem_req_v_o,
  output logic                              mem_we_o,
  output logic [vdp_pkg::word_width_gp-1:0] mem_addr_o,
  output logic [vdp_pkg::word_width_gp-1:0] mem_wdata_o,
  input  logic                              mem_resp_v_i,
  input  logic [vdp_pkg::word_width_gp-1:0] mem_rdata_i,

  output logic                              buf_clear_o,
  output logic                              buf_wr_a_o,
  output logic                              buf_wr_b_o,
  output logic [vdp_pkg::word_width_gp-1:0] buf_data_o,
  output logic                              done_o,
  output logic                              idle_o
);
  import vdp_pkg::*;

  vdp_state_e state_r, state_n;
  logic sum_wait_r;
  logic a_full, b_full;
  logic [word_width_gp-1:0] a_addr, b_addr;

  // a vector is complete at the programmed length or when its buffer is full
  assign a_full = (cnt_a_i == cnt_width_lp'(vec_els_p)) || (word_width_gp'(cnt_a_i) >= len_i);
  assign b_full = (cnt_b_i == cnt_width_lp'(vec_els_p)) || (word_width_gp'(cnt_b_i) >= len_i);

  assign a_addr = a_ptr_i + word_width_gp'(cnt_a_i) * word_width_gp'(word_bytes_gp);
  assign b_addr = b_ptr_i + word_width_gp'(cnt_b_i) * word_width_gp'(word_bytes_gp);

  always_comb begin
    state_n     = state_r;
    mem_req_v_o = 1'b0;
    mem_we_o    = 1'b0;
    mem_addr_o  = a_addr;
    buf_clear_o = 1'b0;
    buf_wr_a_o  = 1'b0;
    buf_wr_b_o  = 1'b0;
    unique case (state_r)
      e_idle: begin
        if (start_i) begin
          state_n = e_clear;
        end
      end
      e_clear: begin
        buf_clear_o = 1'b1;
        state_n     = e_req_a;
      end
      e_req_a: begin
        if (a_full) begin
          state_n = e_req_b;
        end else begin
          mem_req_v_o = 1'b1;
          state_n     = e_wait_a;
        end
      end
      e_wait_a: begin
        if (mem_resp_v_i) begin
          buf_wr_a_o = 1'b1;
          state_n    = e_req_a;
        end
      end
      e_req_b: begin
        mem_addr_o = b_addr;
        if (b_full) begin
          state_n = e_sum;
        end else begin
          mem_req_v_o = 1'b1;
          state_n     = e_wait_b;
        end
      end
      e_wait_b: begin
        mem_addr_o = b_addr;
        if (mem_resp_v_i) begin
          buf_wr_b_o = 1'b1;
          state_n    = e_req_b;
        end
      end
      // two cycles for the product and sum stages of the dot unit
      e_sum: begin
        if (sum_wait_r) begin
          state_n = e_wb;
        end
      end
      e_wb: begin
        mem_req_v_o = 1'b1;
        mem_we_o    = 1'b1;
        mem_addr_o  = res_ptr_i;
        state_n     = e_wait_wb;
      end
      e_wait_wb: begin
        mem_addr_o = res_ptr_i;
        if (mem_resp_v_i) begin
          state_n = e_done;
        end
      end
      e_done: begin
        state_n = e_idle;
      end
      default: begin
        state_n = e_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_idle;
      sum_wait_r <= 1'b0;
    end else begin
      state_r    <= state_n;
      sum_wait_r <= (state_r == e_sum) && !sum_wait_r;
    end
  end

  assign mem_wdata_o = dot_i;
  assign buf_data_o  = mem_rdata_i;
  assign done_o      = (state_r == e_done);
  assign idle_o      = (state_r == e_idle);

endmodule

// ==== vdp_dot_unit.sv ====
module vdp_dot_unit #(
  parameter int vec_els_p = vdp_pkg::vec_els_gp
) (
  input  logic                                             clk_i,
  input  logic [vec_els_p-1:0][vdp_pkg::word_width_gp-1:0] vec_a_i,
  input  logic [vec_els_p-1:0][vdp_pkg::word_width_gp-1:0] vec_b_i,
  output logic [vdp_pkg::word_width_gp-1:0]                dot_o
);
  import vdp_pkg::*;

  logic [vec_els_p-1:0][word_width_gp-1:0] prod_r;
  logic [word_width_gp-1:0] dot_r;

  // heap-ordered adder tree with node 1 as the root and the leaves from vec_els_p up
  logic [word_width_gp-1:0] node [1:2*vec_els_p-1];

  // stage one registers the element products truncated to the word width
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < vec_els_p; i++) begin
      prod_r[i] <= vec_a_i[i] * vec_b_i[i];
    end
  end

  for (genvar i = 0; i < vec_els_p; i++) begin : g_leaf
    assign node[vec_els_p + i] = prod_r[i];
  end

  for (genvar i = 1; i < vec_els_p; i++) begin : g_node
    assign node[i] = node[2*i] + node[2*i + 1];
  end

  // stage two registers the sum modulo 2^64
  always_ff @(posedge clk_i) begin
    dot_r <= node[1];
  end

  assign dot_o = dot_r;

endmodule

// ==== vdp_pkg.sv ====
package vdp_pkg;

  // data path and address width
  localparam int word_width_gp = 64;

  // the default operand buffer depth must be a power of two
  localparam int vec_els_gp = 8;

  // byte stride between consecutive vector elements
  localparam int word_bytes_gp = 8;

  localparam int csr_addr_width_gp = 4;

  // addresses missing from the register map read zero
  typedef enum logic [csr_addr_width_gp-1:0] {
    e_csr_a_ptr   = 4'd0,
    e_csr_b_ptr   = 4'd1,
    e_csr_len     = 4'd2,
    e_csr_start   = 4'd3,
    e_csr_status  = 4'd4,
    e_csr_res_ptr = 4'd5
  } csr_idx_e;

  // sequencer states
  typedef enum logic [3:0] {
    e_idle,
    e_clear,
    e_req_a,
    e_wait_a,
    e_req_b,
    e_wait_b,
    e_sum,
    e_wb,
    e_wait_wb,
    e_done
  } vdp_state_e;

endpackage

// ==== vdp_testdata.txt ====
// first value: number of cases; then per case, one hex value per line:
// length, a_ptr, b_ptr, res_ptr, a[0..length-1], b[0..length-1]
3
// length 8, with wrapping products
8
100
200
300
0000000000000001
0000000000000002
00000000ffffffff
ffffffffffffffff
123456789abcdef0
0000000000000007
8000000000000000
00000000000000ff
0000000000000003
0000000000000005
00000000ffffffff
0000000000000002
0000000000000010
fedcba9876543210
0000000000000003
0000000000000101
// length 3
3
040
080
0c0
000000000000000a
000000000000000b
000000000000000c
0000000000000100
0000000000001000
0000000000010000
// length 1
1
180
1c0
310
deadbeefcafef00d
0000000000000003

// ==== vdp_top.sv ====
module vdp_top #(
  parameter int vec_els_p = vdp_pkg::vec_els_gp
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  input  logic                                  csr_w_v_i,
  input  logic                                  csr_r_v_i,
  input  logic [vdp_pkg::csr_addr_width_gp-1:0] csr_addr_i,
  input  logic [vdp_pkg::word_width_gp-1:0]     csr_wdata_i,
  output logic [vdp_pkg::word_width_gp-1:0]     csr_rdata_o,
  output logic                                  csr_rdata_v_o,

  output logic                                  mem_req_v_o,
  output logic                                  mem_we_o,
  output logic [vdp_pkg::word_width_gp-1:0]     mem_addr_o,
  output logic [vdp_pkg::word_width_gp-1:0]     mem_wdata_o,
  input  logic                                  mem_resp_v_i,
  input  logic [vdp_pkg::word_width_gp-1:0]     mem_rdata_i
);
  import vdp_pkg::*;

  localparam int cnt_width_lp = $clog2(vec_els_p + 1);

  logic start, done, idle;
  logic [word_width_gp-1:0] a_ptr, b_ptr, len, res_ptr;
  logic buf_clear, buf_wr_a, buf_wr_b;
  logic [word_width_gp-1:0] buf_data, dot;
  logic [cnt_width_lp-1:0] cnt_a, cnt_b;
  logic [vec_els_p-1:0][word_width_gp-1:0] vec_a, vec_b;

  vdp_csr i_csr (
    .clk_i, .reset_i,
    .csr_w_v_i, .csr_r_v_i, .csr_addr_i, .csr_wdata_i,
    .csr_rdata_o, .csr_rdata_v_o,
    .done_i(done), .idle_i(idle),
    .a_ptr_o(a_ptr), .b_ptr_o(b_ptr), .len_o(len), .res_ptr_o(res_ptr),
    .start_o(start)
  );

  vdp_ctrl #(.vec_els_p(vec_els_p)) i_ctrl (
    .clk_i, .reset_i,
    .start_i(start), .a_ptr_i(a_ptr), .b_ptr_i(b_ptr), .len_i(len), .res_ptr_i(res_ptr),
    .cnt_a_i(cnt_a), .cnt_b_i(cnt_b), .dot_i(dot),
    .mem_req_v_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_resp_v_i, .mem_rdata_i,
    .buf_clear_o(buf_clear), .buf_wr_a_o(buf_wr_a), .buf_wr_b_o(buf_wr_b),
    .buf_data_o(buf_data), .done_o(done), .idle_o(idle)
  );

  vdp_vector_buf #(.vec_els_p(vec_els_p)) i_buf (
    .clk_i, .reset_i,
    .clear_i(buf_clear), .wr_a_i(buf_wr_a), .wr_b_i(buf_wr_b), .data_i(buf_data),
    .vec_a_o(vec_a), .vec_b_o(vec_b), .cnt_a_o(cnt_a), .cnt_b_o(cnt_b)
  );

  vdp_dot_unit #(.vec_els_p(vec_els_p)) i_dot (
    .clk_i,
    .vec_a_i(vec_a), .vec_b_i(vec_b),
    .dot_o(dot)
  );

endmodule

// ==== vdp_vector_buf.sv ====
module vdp_vector_buf #(
  parameter  int vec_els_p    = vdp_pkg::vec_els_gp,
  localparam int cnt_width_lp = $clog2(vec_els_p + 1)
) (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  logic                                             clear_i,
  input  logic                                             wr_a_i,
  input  logic                                             wr_b_i,
  input  logic [vdp_pkg::word_width_gp-1:0]                data_i,
  output logic [vec_els_p-1:0][vdp_pkg::word_width_gp-1:0] vec_a_o,
  output logic [vec_els_p-1:0][vdp_pkg::word_width_gp-1:0] vec_b_o,
  output logic [cnt_width_lp-1:0]                          cnt_a_o,
  output logic [cnt_width_lp-1:0]                          cnt_b_o
);
  import vdp_pkg::*;

  localparam int idx_width_lp = $clog2(vec_els_p);

  logic [1:0] wr;

  // bank 0 holds operand a, bank 1 operand b
  assign wr = {wr_b_i, wr_a_i};

  for (genvar g = 0; g < 2; g++) begin : g_bank
    logic [vec_els_p-1:0][word_width_gp-1:0] data_r;
    logic [cnt_width_lp-1:0] cnt_r;

    always_ff @(posedge clk_i) begin
      if (reset_i || clear_i) begin
        cnt_r <= '0;
      end else if (wr[g]) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end

    // zeroed on clear so unused elements add nothing to the sum
    always_ff @(posedge clk_i) begin
      if (clear_i) begin
        data_r <= '0;
      end else if (wr[g]) begin
        data_r[cnt_r[idx_width_lp-1:0]] <= data_i;
      end
    end
  end

  assign vec_a_o = g_bank[0].data_r;
  assign vec_b_o = g_bank[1].data_r;
  assign cnt_a_o = g_bank[0].cnt_r;
  assign cnt_b_o = g_bank[1].cnt_r;

endmodule
